// File: decode_stage.sv
`include "rv_defines.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [`ILEN-1:0]    instr,
    output logic [`REG_AW-1:0]  raddr1,
    output logic [`REG_AW-1:0]  raddr2,
    input  logic [`XLEN-1:0]    rdata1,
    input  logic [`XLEN-1:0]    rdata2,
    input  logic                ex_fwd_valid,
    input  logic [`REG_AW-1:0]  ex_fwd_rd,
    input  logic [`XLEN-1:0]    ex_fwd_data,
    stage_if.dst                wb,
    stage_if.src                dx
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`XLEN-1:0]   i_imm;
    logic [`XLEN-1:0]   u_imm;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    dec_payload_t       pl;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign i_imm  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign u_imm  = {instr[31:12], 12'b0};

    assign raddr1 = rs1;
    assign raddr2 = rs2;

    // execute is younger than writeback, so it wins
    function automatic logic [`XLEN-1:0] resolve(input logic [`REG_AW-1:0] idx,
                                                 input logic [`XLEN-1:0]   rf_val);
        logic [`XLEN-1:0] v;
        v = rf_val;
        if (idx != '0) begin
            if (ex_fwd_valid && ex_fwd_rd == idx)
                v = ex_fwd_data;
            else if (wb.valid && wb.rd_we && wb.rd == idx)
                v = wb.payload.result;
        end
        return v;
    endfunction

    always_comb begin
        rs1_val = resolve(rs1, rdata1);
        rs2_val = resolve(rs2, rdata2);
    end

    always_comb begin
        pl          = '0;
        pl.op_a     = rs1_val;
        pl.op_b     = rs2_val;
        pl.rs1      = rs1;
        pl.csr_addr = instr[31:20];
        pl.alu_op   = alu_add;
        pl.illegal  = 1'b1;
        case (opcode)
            op_reg: begin
                pl.illegal = 1'b0;
                if (funct7 == f7_base && funct3 == f3_add_sub) pl.alu_op = alu_add;
                else if (funct7 == f7_sub && funct3 == f3_add_sub) pl.alu_op = alu_sub;
                else if (funct7 == f7_base && funct3 == f3_and) pl.alu_op = alu_and;
                else if (funct7 == f7_base && funct3 == f3_or) pl.alu_op = alu_or;
                else if (funct7 == f7_base && funct3 == f3_xor) pl.alu_op = alu_xor;
                else pl.illegal = 1'b1;
            end
            op_imm: begin
                pl.op_b    = i_imm;
                pl.illegal = (funct3 != f3_addi); // only addi
            end
            op_lui: begin
                pl.alu_op  = alu_pass_b;
                pl.op_b    = u_imm;
                pl.illegal = 1'b0;
            end
            op_system: begin
                if (funct3 == f3_csrrw) begin
                    pl.alu_op  = alu_csr_rw;
                    pl.illegal = 1'b0;
                end else if (funct3 == f3_csrrs) begin
                    pl.alu_op  = alu_csr_rs;
                    pl.illegal = 1'b0;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dx.valid <= 1'b0;
            dx.rd_we <= 1'b0;
        end else begin
            dx.valid <= instr_valid;
            dx.rd_we <= instr_valid && !pl.illegal;
        end
    end

    always_ff @(posedge clk) begin
        dx.rd      <= rd;
        dx.payload <= pl;
    end

endmodule

// File: execute_stage.sv
`include "rv_defines.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                dx,
    output logic [`CSR_AW-1:0]  csr_addr,
    input  logic [`XLEN-1:0]    csr_rdata,
    output logic                csr_we,
    output logic [`XLEN-1:0]    csr_wdata,
    output logic                fwd_valid,
    output logic [`REG_AW-1:0]  fwd_rd,
    output logic [`XLEN-1:0]    fwd_data,
    stage_if.src                xw
);
    import rv_pipe_pkg::*;

    logic [`XLEN-1:0] result;
    wb_payload_t      pl;

    assign csr_addr = dx.payload.csr_addr;

    always_comb begin
        case (dx.payload.alu_op)
            alu_add:    result = dx.payload.op_a + dx.payload.op_b;
            alu_sub:    result = dx.payload.op_a - dx.payload.op_b;
            alu_and:    result = dx.payload.op_a & dx.payload.op_b;
            alu_or:     result = dx.payload.op_a | dx.payload.op_b;
            alu_xor:    result = dx.payload.op_a ^ dx.payload.op_b;
            alu_pass_b: result = dx.payload.op_b;
            default:    result = csr_rdata; // csr ops return the old value
        endcase
        if (dx.payload.illegal)
            result = '0;
    end

    // csrrs with rs1 = x0 is a pure read
    assign csr_we = dx.valid && !dx.payload.illegal &&
                    (dx.payload.alu_op == alu_csr_rw ||
                     (dx.payload.alu_op == alu_csr_rs && dx.payload.rs1 != '0));
    assign csr_wdata = (dx.payload.alu_op == alu_csr_rw) ? dx.payload.op_a
                                                         : (csr_rdata | dx.payload.op_a);

    assign fwd_valid = dx.valid && dx.rd_we;
    assign fwd_rd    = dx.rd;
    assign fwd_data  = result;

    assign pl.result  = result;
    assign pl.illegal = dx.payload.illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            xw.valid <= 1'b0;
            xw.rd_we <= 1'b0;
        end else begin
            xw.valid <= dx.valid;
            xw.rd_we <= dx.valid && dx.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        xw.rd      <= dx.rd;
        xw.payload <= pl;
    end

endmodule

// File: reg_csr_file.sv
`include "rv_defines.svh"

module reg_csr_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [`REG_AW-1:0]  raddr1,
    input  logic [`REG_AW-1:0]  raddr2,
    output logic [`XLEN-1:0]    rdata1,
    output logic [`XLEN-1:0]    rdata2,
    input  logic                wen,
    input  logic [`REG_AW-1:0]  waddr,
    input  logic [`XLEN-1:0]    wdata,
    input  logic [`CSR_AW-1:0]  csr_addr,
    output logic [`XLEN-1:0]    csr_rdata,
    input  logic                csr_we,
    input  logic [`XLEN-1:0]    csr_wdata,
    output logic [`XLEN-1:0]    a0,
    output logic [`XLEN-1:0]    mepc,
    output logic [`XLEN-1:0]    mtvec
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] regs [`NREGS];
    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign a0     = regs[10];

    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_rdata = mstatus_q;
            csr_mtvec:   csr_rdata = mtvec_q;
            csr_mepc:    csr_rdata = mepc_q;
            csr_mcause:  csr_rdata = mcause_q;
            default:     csr_rdata = '0; // unimplemented csr
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= mstatus_rst;
            mtvec_q   <= mtvec_rst;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                csr_mstatus: mstatus_q <= csr_wdata;
                csr_mtvec:   mtvec_q   <= csr_wdata;
                csr_mepc:    mepc_q    <= csr_wdata;
                csr_mcause:  mcause_q  <= csr_wdata;
                default: ;
            endcase
        end
    end

    assign mepc  = mepc_q;
    assign mtvec = mtvec_q;

endmodule

// File: rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path width
`define XLEN 32

// general register count and index width
`define NREGS 32
`define REG_AW 5

// csr address width, fixed by the ISA
`define CSR_AW 12

// instruction word width
`define ILEN 32

`endif

// File: rv_exec_sva.sv
`include "rv_defines.svh"

module rv_exec_sva (
    input logic               clk,
    input logic               rst,
    input logic               instr_valid,
    input logic               retire_valid,
    input logic [31:0]        instret,
    input logic [`XLEN-1:0]   a0
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // fixed two-edge latency, both directions
    issue_to_retire: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##2 retire_valid)
    else begin
        fail_count++;
        $error("retire_valid did not follow instr_valid after two cycles");
    end

    retire_from_issue: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> $past(instr_valid, 2))
    else begin
        fail_count++;
        $error("retire_valid without instr_valid two cycles earlier");
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!retire_valid && instret == '0))
    else begin
        fail_count++;
        $error("outputs active while in reset");
    end

    // a0 only moves at the edge that ends a retire cycle
    a0_holds: assert property (@(posedge clk) disable iff (rst)
        !retire_valid |=> $stable(a0))
    else begin
        fail_count++;
        $error("a0 changed in a cycle with no retire");
    end

endmodule

bind rv_exec_top rv_exec_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .instret      (instret),
    .a0           (a0)
);

// File: rv_exec_top.sv
`include "rv_defines.svh"

module rv_exec_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [`ILEN-1:0]    instr,
    output logic                retire_valid,
    output logic [`REG_AW-1:0]  retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                retire_illegal,
    output logic [31:0]         instret,
    output logic [`XLEN-1:0]    a0,
    output logic [`XLEN-1:0]    mepc,
    output logic [`XLEN-1:0]    mtvec
);
    import rv_pipe_pkg::*;

    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;
    logic               wen;
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0]   wdata;
    logic [`CSR_AW-1:0] csr_addr;
    logic [`XLEN-1:0]   csr_rdata;
    logic               csr_we;
    logic [`XLEN-1:0]   csr_wdata;
    logic               ex_fwd_valid;
    logic [`REG_AW-1:0] ex_fwd_rd;
    logic [`XLEN-1:0]   ex_fwd_data;

    stage_if #(.payload_t(dec_payload_t)) dx ();
    stage_if #(.payload_t(wb_payload_t))  xw ();

    decode_stage u_decode (
        .clk, .rst, .instr_valid, .instr,
        .raddr1, .raddr2, .rdata1, .rdata2,
        .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
        .wb (xw.dst),
        .dx (dx.src)
    );

    execute_stage u_execute (
        .clk, .rst,
        .dx (dx.dst),
        .csr_addr, .csr_rdata, .csr_we, .csr_wdata,
        .fwd_valid (ex_fwd_valid),
        .fwd_rd    (ex_fwd_rd),
        .fwd_data  (ex_fwd_data),
        .xw (xw.src)
    );

    writeback_stage u_writeback (
        .clk, .rst,
        .xw (xw.dst),
        .wen, .waddr, .wdata,
        .retire_valid, .retire_rd, .retire_data, .retire_illegal,
        .instret
    );

    reg_csr_file u_regs (
        .clk, .rst,
        .raddr1, .raddr2, .rdata1, .rdata2,
        .wen, .waddr, .wdata,
        .csr_addr, .csr_rdata, .csr_we, .csr_wdata,
        .a0, .mepc, .mtvec
    );

endmodule

// File: rv_isa_pkg.sv
`include "rv_defines.svh"

package rv_isa_pkg;

    // major opcodes of the subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_csrrw   = 3'b001;
    localparam logic [2:0] f3_csrrs   = 3'b010;

    // funct7
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // machine csr addresses
    localparam logic [`CSR_AW-1:0] csr_mstatus = 12'h300;
    localparam logic [`CSR_AW-1:0] csr_mtvec   = 12'h305;
    localparam logic [`CSR_AW-1:0] csr_mepc    = 12'h341;
    localparam logic [`CSR_AW-1:0] csr_mcause  = 12'h342;

    // csr reset values
    localparam logic [`XLEN-1:0] mstatus_rst = 32'h0000_1800; // mpp = machine
    localparam logic [`XLEN-1:0] mtvec_rst   = 32'h8000_0000;

endpackage

// File: rv_pipe_pkg.sv
`include "rv_defines.svh"

package rv_pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b, // lui
        alu_csr_rw,
        alu_csr_rs
    } alu_op_t;

    // decode -> execute
    typedef struct packed {
        alu_op_t            alu_op;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;
        logic [`CSR_AW-1:0] csr_addr;
        logic [`REG_AW-1:0] rs1;     // csrrs writes only when nonzero
        logic               illegal;
    } dec_payload_t;

    // execute -> writeback
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic             illegal;
    } wb_payload_t;

endpackage

// File: stage_if.sv
`include "rv_defines.svh"

// one pipeline register slot between two neighbouring stages
interface stage_if #(
    parameter type payload_t = logic
);

    logic               valid;   // stage holds an item this cycle
    logic [`REG_AW-1:0] rd;
    logic               rd_we;
    payload_t           payload;

    // producer side, all four driven from flops
    modport src (
        output valid,
        output rd,
        output rd_we,
        output payload
    );

    modport dst (
        input valid,
        input rd,
        input rd_we,
        input payload
    );

endinterface

// File: tb.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
stage_if.sv
reg_csr_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
rv_exec_top.sv
rv_exec_sva.sv
tb_rv_exec.sv

// File: tb_rv_exec.sv
`include "rv_defines.svh"

module tb_rv_exec;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_random   = 400;
    localparam int clk_period = 4;
    // reset, directed prelude, random stream, drain margin
    localparam int timeout_ns = (5 + 5 + n_random + 50) * clk_period;

    typedef struct {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        illegal;
        logic [31:0] a0;    // before this instruction
        logic [31:0] mepc;  // after it
        logic [31:0] mtvec;
    } exp_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [31:0]        instr;
    logic               retire_valid;
    logic [`REG_AW-1:0] retire_rd;
    logic [`XLEN-1:0]   retire_data;
    logic               retire_illegal;
    logic [31:0]        instret;
    logic [`XLEN-1:0]   a0;
    logic [`XLEN-1:0]   mepc;
    logic [`XLEN-1:0]   mtvec;

    logic [31:0] m_regs [32];
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    exp_t        exp_q [$];
    int          errors  = 0;
    int          checks  = 0;
    int          issued  = 0;
    int          retired = 0;

    rv_exec_top i_rv_exec_top (
        .clk, .rst, .instr_valid, .instr,
        .retire_valid, .retire_rd, .retire_data, .retire_illegal,
        .instret, .a0, .mepc, .mtvec
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] csr_get(input logic [11:0] addr);
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            default: return 32'h0; // not implemented
        endcase
    endfunction

    task automatic csr_put(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            12'h300: m_mstatus = val;
            12'h305: m_mtvec   = val;
            12'h341: m_mepc    = val;
            12'h342: m_mcause  = val;
            default: ;
        endcase
    endtask

    function automatic bit decode_ok(input logic [31:0] w);
        case (w[6:0])
            7'h33: return (w[31:25] == 7'h00 && w[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111})
                       || (w[31:25] == 7'h20 && w[14:12] == 3'b000);
            7'h13: return w[14:12] == 3'b000; // addi
            7'h37: return 1'b1;
            7'h73: return w[14:12] inside {3'b001, 3'b010};
            default: return 1'b0;
        endcase
    endfunction

    // architectural model, one instruction in program order
    task automatic run_model(input logic [31:0] w, output exp_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] old;
        a    = m_regs[w[19:15]];
        b    = m_regs[w[24:20]];
        res  = 32'h0;
        e.a0 = m_regs[10];
        if (decode_ok(w)) begin
            case (w[6:0])
                7'h33: begin
                    case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        default: res = a ^ b;
                    endcase
                end
                7'h13: res = a + {{20{w[31]}}, w[31:20]};
                7'h37: res = {w[31:12], 12'h000};
                default: begin
                    old = csr_get(w[31:20]);
                    res = old;
                    if (w[14:12] == 3'b001)
                        csr_put(w[31:20], a);
                    else if (w[19:15] != 5'd0)
                        csr_put(w[31:20], old | a);
                end
            endcase
            if (w[11:7] != 5'd0)
                m_regs[w[11:7]] = res;
        end
        e.rd      = w[11:7];
        e.data    = res;
        e.illegal = !decode_ok(w);
        e.mepc    = m_mepc;
        e.mtvec   = m_mtvec;
    endtask

    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 7) == 0)
            return 5'd10; // a0
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic logic [31:0] random_legal();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] csr;
        logic [11:0] imm12;
        logic [19:0] imm20;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        case ($urandom_range(0, 4))
            0:       csr = 12'h300;
            1:       csr = 12'h305;
            2:       csr = 12'h341;
            3:       csr = 12'h342;
            default: csr = 12'h7c0; // unknown csr
        endcase
        case ($urandom_range(0, 8))
            0:       return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
            1:       return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
            2:       return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
            3:       return {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
            4:       return {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
            5:       return {imm12, rs1, 3'b000, rd, 7'h13};
            6:       return {imm20, rd, 7'h37};
            7:       return {csr, rs1, 3'b001, rd, 7'h73};
            default: return {csr, rs1, 3'b010, rd, 7'h73};
        endcase
    endfunction

    task automatic issue(input logic [31:0] w);
        exp_t e;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        run_model(w, e);
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= $urandom; // ignored word
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (!rst && retire_valid) begin
            assert (exp_q.size() != 0)
            else begin
                errors++;
                $display("retire at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                compare_field("retire_rd", retire_rd, e.rd);
                compare_field("retire_data", retire_data, e.data);
                compare_field("retire_illegal", retire_illegal, e.illegal);
                compare_field("instret", instret, retired);
                compare_field("a0", a0, e.a0);
                compare_field("mepc", mepc, e.mepc);
                compare_field("mtvec", mtvec, e.mtvec);
                retired++;
            end
        end
    end

    initial begin
        logic [31:0] w;
        int          r;
        void'($urandom(9356));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = 32'h0;
        m_mstatus = 32'h0000_1800;
        m_mtvec   = 32'h8000_0000;
        m_mepc    = 32'h0;
        m_mcause  = 32'h0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        issue({12'h300, 5'd0, 3'b010, 5'd1, 7'h73}); // read mstatus reset value
        issue({12'h305, 5'd0, 3'b010, 5'd2, 7'h73}); // read mtvec reset value
        issue({12'h055, 5'd0, 3'b000, 5'd0, 7'h13}); // addi x0, x0, 0x55
        issue({7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'h33});
        issue({12'h341, 5'd0, 3'b010, 5'd4, 7'h73});
        for (int i = 0; i < n_random; i++) begin
            r = $urandom_range(0, 99);
            if (r < 10) begin
                idle_cycle();
            end else if (r < 20) begin
                do
                    w = $urandom;
                while (decode_ok(w));
                issue(w);
            end else begin
                issue(random_legal());
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
        compare_field("instret", instret, issued);
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_rv_exec_top.u_sva.fail_count);
        if (errors == 0 && i_rv_exec_top.u_sva.fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, retire stream never drained", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: writeback_stage.sv
`include "rv_defines.svh"

module writeback_stage (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                xw,
    output logic                wen,
    output logic [`REG_AW-1:0]  waddr,
    output logic [`XLEN-1:0]    wdata,
    output logic                retire_valid,
    output logic [`REG_AW-1:0]  retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                retire_illegal,
    output logic [31:0]         instret
);

    // no commit for illegal words or x0
    assign wen   = xw.valid && xw.rd_we && !xw.payload.illegal && xw.rd != '0;
    assign waddr = xw.rd;
    assign wdata = xw.payload.result;

    assign retire_valid   = xw.valid;
    assign retire_rd      = xw.rd;
    assign retire_data    = xw.payload.result;
    assign retire_illegal = xw.payload.illegal;

    always_ff @(posedge clk) begin
        if (rst)
            instret <= '0;
        else if (xw.valid)
            instret <= instret + 32'd1; // illegal ones count too
    end

endmodule
